// ==== logic/pagerank_pkg.sv ====
// PageRank scatter engine
// Shared widths, depths and payload types

package pagerank_pkg;

	// Vertex and edge address space
	localparam int VERTEX_W = 6;
	localparam int EDGE_W   = 8;

	// Rank is unsigned, inverse degree is 0.16 fixed point
	localparam int RANK_W    = 16;
	localparam int INV_W     = 16;
	localparam int CONTRIB_W = 16;

	// Next-rank entries wrap modulo 2**ACC_W
	localparam int ACC_W   = 24;
	localparam int COUNT_W = 16;

	// Queue depths
	localparam int JOB_DEPTH     = 16;
	localparam int CONTRIB_DEPTH = 4;

	// One out_degree bit more than the edge address so 256 edges fit
	typedef struct packed {
		logic [RANK_W-1:0] rank;
		logic [INV_W-1:0]  inv_degree;
		logic [EDGE_W-1:0] edge_base;
		logic [EDGE_W:0]   out_degree;
	} vertex_job_t;

	typedef struct packed {
		logic [VERTEX_W-1:0]  dest;
		logic [CONTRIB_W-1:0] value;
	} contrib_t;

endpackage

// ==== logic/sync_fifo.sv ====
// Synchronous queue, generic payload

`timescale 1ns/1ps

module sync_fifo #(
	parameter type item_t = logic [7:0],
	parameter int  DEPTH  = 4
) (
	input  logic  clock,
	input  logic  rstn,
	input  logic  push,
	input  item_t data_in,
	input  logic  pop,
	output item_t data_out,
	output logic  empty,
	output logic  full,
	output logic  almost_full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	item_t             mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              do_push;
	logic              do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty       = (count == '0);
	assign full        = (count == CNT_W'(DEPTH));
	assign almost_full = (count >= CNT_W'(DEPTH - 1));
	// Head is visible without a read cycle
	assign data_out    = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

endmodule

// ==== logic/vertex_dispatch.sv ====
// Vertex job queue and dispatch

`timescale 1ns/1ps

module vertex_dispatch #(
	parameter int NUM_CU = 4
) (
	input  logic                                          clock,
	input  logic                                          rstn,
	input  logic                                          job_strobe,
	input  logic [pagerank_pkg::RANK_W-1:0]               job_rank,
	input  logic [pagerank_pkg::INV_W-1:0]                job_inv_degree,
	input  logic [pagerank_pkg::EDGE_W-1:0]               job_edge_base,
	input  logic [pagerank_pkg::EDGE_W:0]                 job_out_degree,
	input  logic [NUM_CU-1:0]                             cu_idle,
	output logic [NUM_CU-1:0]                             cu_start,
	output logic [NUM_CU-1:0][pagerank_pkg::RANK_W-1:0]   cu_rank,
	output logic [NUM_CU-1:0][pagerank_pkg::INV_W-1:0]    cu_inv_degree,
	output logic [NUM_CU-1:0][pagerank_pkg::EDGE_W-1:0]   cu_edge_base,
	output logic [NUM_CU-1:0][pagerank_pkg::EDGE_W:0]     cu_out_degree,
	output logic                                          queue_empty
);

	import pagerank_pkg::*;

	vertex_job_t job_in;
	vertex_job_t job_head;
	logic        fifo_empty;
	logic        job_pop;

	assign job_in.rank       = job_rank;
	assign job_in.inv_degree = job_inv_degree;
	assign job_in.edge_base  = job_edge_base;
	assign job_in.out_degree = job_out_degree;

	sync_fifo #(
		.item_t(vertex_job_t),
		.DEPTH (JOB_DEPTH)
	) u_job_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (job_strobe),
		.data_in    (job_in),
		.pop        (job_pop),
		.data_out   (job_head),
		.empty      (fifo_empty),
		.full       (),
		.almost_full()
	);

	// A job arriving this cycle already counts as pending work
	assign queue_empty = fifo_empty && !job_strobe;

	//////////////////////////////////////////////////////////////////////
	// Hand the head job to the lowest idle unit
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		job_pop       = 1'b0;
		cu_start      = '0;
		cu_rank       = '0;
		cu_inv_degree = '0;
		cu_edge_base  = '0;
		cu_out_degree = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			if (!job_pop && !fifo_empty && cu_idle[i]) begin
				job_pop          = 1'b1;
				cu_start[i]      = 1'b1;
				cu_rank[i]       = job_head.rank;
				cu_inv_degree[i] = job_head.inv_degree;
				cu_edge_base[i]  = job_head.edge_base;
				cu_out_degree[i] = job_head.out_degree;
			end
		end
	end

endmodule

// ==== logic/edge_list_mem.sv ====
// Edge list, destination vertex per edge

`timescale 1ns/1ps

module edge_list_mem #(
	parameter int NUM_CU = 4
) (
	input  logic                                        clock,
	input  logic                                        edge_wr,
	input  logic [pagerank_pkg::EDGE_W-1:0]             edge_wr_addr,
	input  logic [pagerank_pkg::VERTEX_W-1:0]           edge_wr_dest,
	input  logic [NUM_CU-1:0][pagerank_pkg::EDGE_W-1:0] edge_rd_addr,
	output logic [NUM_CU-1:0][pagerank_pkg::VERTEX_W-1:0] edge_rd_dest
);

	import pagerank_pkg::*;

	localparam int NUM_EDGES = 1 << EDGE_W;

	logic [VERTEX_W-1:0] dest_mem [NUM_EDGES];

	always_ff @(posedge clock) begin
		if (edge_wr) begin
			dest_mem[edge_wr_addr] <= edge_wr_dest;
		end
	end

	// One asynchronous read port per unit
	always_comb begin
		for (int i = 0; i < NUM_CU; i++) begin
			edge_rd_dest[i] = dest_mem[edge_rd_addr[i]];
		end
	end

endmodule

// ==== logic/cu_vertex_pagerank.sv ====
// PageRank compute unit, one vertex at a time

`timescale 1ns/1ps

module cu_vertex_pagerank (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               cu_start,
	input  logic [pagerank_pkg::RANK_W-1:0]    cu_rank,
	input  logic [pagerank_pkg::INV_W-1:0]     cu_inv_degree,
	input  logic [pagerank_pkg::EDGE_W-1:0]    cu_edge_base,
	input  logic [pagerank_pkg::EDGE_W:0]      cu_out_degree,
	input  logic                               contrib_stall,
	input  logic [pagerank_pkg::VERTEX_W-1:0]  edge_rd_dest,
	output logic                               cu_idle,
	output logic [pagerank_pkg::EDGE_W-1:0]    edge_rd_addr,
	output logic                               contrib_strobe,
	output logic [pagerank_pkg::VERTEX_W-1:0]  contrib_dest,
	output logic [pagerank_pkg::CONTRIB_W-1:0] contrib_value,
	output logic                               vertex_done
);

	import pagerank_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_CALC, S_WALK, S_DONE} state_t;

	state_t                    state;
	logic [RANK_W-1:0]         rank_q;
	logic [INV_W-1:0]          inv_q;
	logic [CONTRIB_W-1:0]      contrib_q;
	logic [RANK_W+INV_W-1:0]   product;
	logic [EDGE_W:0]           remaining;
	logic [EDGE_W-1:0]         edge_addr;
	logic                      step;

	// Keep the integer part of rank * 0.16 fraction
	assign product = rank_q * inv_q;
	assign step    = (state == S_WALK) && !contrib_stall;

	assign cu_idle        = (state == S_IDLE);
	assign edge_rd_addr   = edge_addr;
	assign contrib_strobe = step;
	assign contrib_dest   = edge_rd_dest;
	assign contrib_value  = contrib_q;
	assign vertex_done    = (state == S_DONE) || (step && remaining == (EDGE_W+1)'(1));

	//////////////////////////////////////////////////////////////////////
	// Job latch and contribution
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (cu_start && state == S_IDLE) begin
			rank_q <= cu_rank;
			inv_q  <= cu_inv_degree;
		end
		if (state == S_CALC) begin
			contrib_q <= product[RANK_W+INV_W-1 -: CONTRIB_W];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Edge walk
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= S_IDLE;
			remaining <= '0;
			edge_addr <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (cu_start) begin
						state     <= S_CALC;
						remaining <= cu_out_degree;
						edge_addr <= cu_edge_base;
					end
				end
				S_CALC: begin
					// No edges, report completion right away
					state <= (remaining == '0) ? S_DONE : S_WALK;
				end
				S_WALK: begin
					if (step) begin
						remaining <= remaining - 1'b1;
						// Wraps at the end of the edge memory
						edge_addr <= edge_addr + 1'b1;
						if (remaining == (EDGE_W+1)'(1)) begin
							state <= S_IDLE;
						end
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== logic/rank_accumulator.sv ====
// Contribution accumulator and next-rank array

`timescale 1ns/1ps

module rank_accumulator #(
	parameter int NUM_CU = 4
) (
	input  logic                                           clock,
	input  logic                                           rstn,
	input  logic [NUM_CU-1:0]                              contrib_strobe,
	input  logic [NUM_CU-1:0][pagerank_pkg::VERTEX_W-1:0]  contrib_dest,
	input  logic [NUM_CU-1:0][pagerank_pkg::CONTRIB_W-1:0] contrib_value,
	input  logic [NUM_CU-1:0]                              vertex_done,
	input  logic [NUM_CU-1:0]                              cu_idle,
	input  logic                                           queue_empty,
	input  logic                                           clear,
	input  logic                                           rd_strobe,
	input  logic [pagerank_pkg::VERTEX_W-1:0]              rd_addr,
	output logic [NUM_CU-1:0]                              contrib_stall,
	output logic [pagerank_pkg::ACC_W-1:0]                 rd_data,
	output logic                                           rd_valid,
	output logic                                           busy,
	output logic [pagerank_pkg::COUNT_W-1:0]               vertex_count,
	output logic [pagerank_pkg::COUNT_W-1:0]               edge_count
);

	import pagerank_pkg::*;

	localparam int SEL_W       = (NUM_CU > 1) ? $clog2(NUM_CU) : 1;
	localparam int NUM_VERTEX  = 1 << VERTEX_W;

	contrib_t             fifo_in   [NUM_CU];
	contrib_t             fifo_head [NUM_CU];
	logic [NUM_CU-1:0]    fifo_empty;
	logic [NUM_CU-1:0]    pop;
	logic                 pop_any;
	logic [SEL_W-1:0]     sel;
	logic [SEL_W-1:0]     rr_ptr;
	contrib_t             head;
	logic [COUNT_W-1:0]   done_sum;
	logic [ACC_W-1:0]     next_rank [NUM_VERTEX];

	for (genvar i = 0; i < NUM_CU; i++) begin : g_queue
		assign fifo_in[i].dest  = contrib_dest[i];
		assign fifo_in[i].value = contrib_value[i];

		sync_fifo #(
			.item_t(contrib_t),
			.DEPTH (CONTRIB_DEPTH)
		) u_contrib_fifo (
			.clock      (clock),
			.rstn       (rstn),
			.push       (contrib_strobe[i]),
			.data_in    (fifo_in[i]),
			.pop        (pop[i]),
			.data_out   (fifo_head[i]),
			.empty      (fifo_empty[i]),
			.full       (),
			.almost_full(contrib_stall[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Round-robin pick, starting after the last unit served
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		int idx;
		pop     = '0;
		pop_any = 1'b0;
		sel     = rr_ptr;
		for (int k = 1; k <= NUM_CU; k++) begin
			idx = (int'(rr_ptr) + k) % NUM_CU;
			if (!pop_any && !fifo_empty[idx]) begin
				pop_any = 1'b1;
				sel     = SEL_W'(idx);
			end
		end
		if (pop_any) begin
			pop[sel] = 1'b1;
		end
	end

	assign head = fifo_head[sel];

	// Several units may finish in the same cycle
	always_comb begin
		done_sum = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			done_sum = done_sum + COUNT_W'(vertex_done[i]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next-rank array, counters and status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int v = 0; v < NUM_VERTEX; v++) begin
				next_rank[v] <= '0;
			end
			rr_ptr       <= '0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else if (clear) begin
			for (int v = 0; v < NUM_VERTEX; v++) begin
				next_rank[v] <= '0;
			end
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			if (pop_any) begin
				// Read-modify-write, sum wraps at ACC_W bits
				next_rank[head.dest] <= next_rank[head.dest] + ACC_W'(head.value);
				rr_ptr               <= sel;
				edge_count           <= edge_count + 1'b1;
			end
			vertex_count <= vertex_count + done_sum;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_valid <= 1'b0;
			busy     <= 1'b0;
		end else begin
			rd_valid <= rd_strobe;
			busy     <= !(queue_empty && (&cu_idle) && (&fifo_empty));
		end
	end

	always_ff @(posedge clock) begin
		if (rd_strobe) begin
			rd_data <= next_rank[rd_addr];
		end
	end

endmodule

// ==== logic/pagerank_engine.sv ====
// PageRank scatter engine, top level

`timescale 1ns/1ps

module pagerank_engine #(
	parameter int NUM_CU = 4
) (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              job_strobe,
	input  logic [pagerank_pkg::RANK_W-1:0]   job_rank,
	input  logic [pagerank_pkg::INV_W-1:0]    job_inv_degree,
	input  logic [pagerank_pkg::EDGE_W-1:0]   job_edge_base,
	input  logic [pagerank_pkg::EDGE_W:0]     job_out_degree,
	input  logic                              edge_wr,
	input  logic [pagerank_pkg::EDGE_W-1:0]   edge_wr_addr,
	input  logic [pagerank_pkg::VERTEX_W-1:0] edge_wr_dest,
	input  logic                              clear,
	input  logic                              rd_strobe,
	input  logic [pagerank_pkg::VERTEX_W-1:0] rd_addr,
	output logic [pagerank_pkg::ACC_W-1:0]    rd_data,
	output logic                              rd_valid,
	output logic                              busy,
	output logic [pagerank_pkg::COUNT_W-1:0]  vertex_count,
	output logic [pagerank_pkg::COUNT_W-1:0]  edge_count
);

	import pagerank_pkg::*;

	// Dispatcher to units
	logic [NUM_CU-1:0]                 cu_start;
	logic [NUM_CU-1:0][RANK_W-1:0]     cu_rank;
	logic [NUM_CU-1:0][INV_W-1:0]      cu_inv_degree;
	logic [NUM_CU-1:0][EDGE_W-1:0]     cu_edge_base;
	logic [NUM_CU-1:0][EDGE_W:0]       cu_out_degree;
	logic [NUM_CU-1:0]                 cu_idle;
	logic                              queue_empty;

	// Units to edge memory and accumulator
	logic [NUM_CU-1:0][EDGE_W-1:0]     edge_rd_addr;
	logic [NUM_CU-1:0][VERTEX_W-1:0]   edge_rd_dest;
	logic [NUM_CU-1:0]                 contrib_strobe;
	logic [NUM_CU-1:0][VERTEX_W-1:0]   contrib_dest;
	logic [NUM_CU-1:0][CONTRIB_W-1:0]  contrib_value;
	logic [NUM_CU-1:0]                 vertex_done;
	logic [NUM_CU-1:0]                 contrib_stall;

	vertex_dispatch #(.NUM_CU(NUM_CU)) u_dispatch (
		.clock         (clock),
		.rstn          (rstn),
		.job_strobe    (job_strobe),
		.job_rank      (job_rank),
		.job_inv_degree(job_inv_degree),
		.job_edge_base (job_edge_base),
		.job_out_degree(job_out_degree),
		.cu_idle       (cu_idle),
		.cu_start      (cu_start),
		.cu_rank       (cu_rank),
		.cu_inv_degree (cu_inv_degree),
		.cu_edge_base  (cu_edge_base),
		.cu_out_degree (cu_out_degree),
		.queue_empty   (queue_empty)
	);

	edge_list_mem #(.NUM_CU(NUM_CU)) u_edge_mem (
		.clock       (clock),
		.edge_wr     (edge_wr),
		.edge_wr_addr(edge_wr_addr),
		.edge_wr_dest(edge_wr_dest),
		.edge_rd_addr(edge_rd_addr),
		.edge_rd_dest(edge_rd_dest)
	);

	for (genvar i = 0; i < NUM_CU; i++) begin : g_cu
		cu_vertex_pagerank u_cu (
			.clock         (clock),
			.rstn          (rstn),
			.cu_start      (cu_start[i]),
			.cu_rank       (cu_rank[i]),
			.cu_inv_degree (cu_inv_degree[i]),
			.cu_edge_base  (cu_edge_base[i]),
			.cu_out_degree (cu_out_degree[i]),
			.contrib_stall (contrib_stall[i]),
			.edge_rd_dest  (edge_rd_dest[i]),
			.cu_idle       (cu_idle[i]),
			.edge_rd_addr  (edge_rd_addr[i]),
			.contrib_strobe(contrib_strobe[i]),
			.contrib_dest  (contrib_dest[i]),
			.contrib_value (contrib_value[i]),
			.vertex_done   (vertex_done[i])
		);
	end

	rank_accumulator #(.NUM_CU(NUM_CU)) u_accum (
		.clock         (clock),
		.rstn          (rstn),
		.contrib_strobe(contrib_strobe),
		.contrib_dest  (contrib_dest),
		.contrib_value (contrib_value),
		.vertex_done   (vertex_done),
		.cu_idle       (cu_idle),
		.queue_empty   (queue_empty),
		.clear         (clear),
		.rd_strobe     (rd_strobe),
		.rd_addr       (rd_addr),
		.contrib_stall (contrib_stall),
		.rd_data       (rd_data),
		.rd_valid      (rd_valid),
		.busy          (busy),
		.vertex_count  (vertex_count),
		.edge_count    (edge_count)
	);

endmodule

// ==== verif/pagerank_assert.sv ====
// PageRank engine assertions

`timescale 1ns/1ps

module pagerank_assert #(
	parameter int NUM_CU = 4
) (
	input logic              clock,
	input logic              rstn,
	input logic              job_strobe,
	input logic [NUM_CU-1:0] cu_start,
	input logic [NUM_CU-1:0] contrib_strobe,
	input logic [NUM_CU-1:0] contrib_stall,
	input logic              rd_strobe,
	input logic              rd_valid
);

	import pagerank_pkg::*;

	// Job queue level, tracked from pushes and dispatches
	int job_level;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_level <= 0;
		end else begin
			job_level <= job_level + int'(job_strobe && job_level < JOB_DEPTH)
				- int'(|cu_start);
		end
	end

	a_job_not_full: assert property (@(posedge clock) disable iff (!rstn)
		job_strobe |-> job_level < JOB_DEPTH)
		else $error("job pushed into a full queue");

	a_start_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cu_start))
		else $error("more than one unit started in a cycle");

	a_rd_follow: assert property (@(posedge clock) disable iff (!rstn)
		rd_strobe |=> rd_valid)
		else $error("rd_valid missing after rd_strobe");

	a_rd_only: assert property (@(posedge clock) disable iff (!rstn)
		rd_valid |-> $past(rd_strobe))
		else $error("rd_valid without a preceding rd_strobe");

	// Also keeps every contribution queue from a push while full
	a_stall_hold: assert property (@(posedge clock) disable iff (!rstn)
		(contrib_strobe & contrib_stall) == '0)
		else $error("stalled unit emitted a contribution");

endmodule

bind pagerank_engine pagerank_assert #(.NUM_CU(NUM_CU)) u_assert (
	.clock         (clock),
	.rstn          (rstn),
	.job_strobe    (job_strobe),
	.cu_start      (cu_start),
	.contrib_strobe(contrib_strobe),
	.contrib_stall (contrib_stall),
	.rd_strobe     (rd_strobe),
	.rd_valid      (rd_valid)
);

// ==== verif/pagerank_tb.sv ====
// PageRank scatter engine testbench

`timescale 1ns/1ps

module pagerank_tb;

	import pagerank_pkg::*;

	// Jobs times the largest degree, plus loads and readouts, with margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic                 clock = 1'b0;
	logic                 rstn;
	logic                 job_strobe;
	logic [RANK_W-1:0]    job_rank;
	logic [INV_W-1:0]     job_inv_degree;
	logic [EDGE_W-1:0]    job_edge_base;
	logic [EDGE_W:0]      job_out_degree;
	logic                 edge_wr;
	logic [EDGE_W-1:0]    edge_wr_addr;
	logic [VERTEX_W-1:0]  edge_wr_dest;
	logic                 clear;
	logic                 rd_strobe;
	logic [VERTEX_W-1:0]  rd_addr;
	logic [ACC_W-1:0]     rd_data;
	logic                 rd_valid;
	logic                 busy;
	logic [COUNT_W-1:0]   vertex_count;
	logic [COUNT_W-1:0]   edge_count;

	// Reference model
	logic [VERTEX_W-1:0]  model_dest [256];
	logic [ACC_W-1:0]     model_rank [64];
	logic [COUNT_W-1:0]   exp_vertex;
	logic [COUNT_W-1:0]   exp_edge;

	int errors = 0;
	int reads = 0;
	int cycles = 0;
	int stall_cycles = 0;
	int stall_base = 0;

	pagerank_engine #(.NUM_CU(4)) DUT (
		.clock         (clock),
		.rstn          (rstn),
		.job_strobe    (job_strobe),
		.job_rank      (job_rank),
		.job_inv_degree(job_inv_degree),
		.job_edge_base (job_edge_base),
		.job_out_degree(job_out_degree),
		.edge_wr       (edge_wr),
		.edge_wr_addr  (edge_wr_addr),
		.edge_wr_dest  (edge_wr_dest),
		.clear         (clear),
		.rd_strobe     (rd_strobe),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.rd_valid      (rd_valid),
		.busy          (busy),
		.vertex_count  (vertex_count),
		.edge_count    (edge_count)
	);

	always #50 clock = ~clock;

	// Watchdog and stall monitor
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (DUT.contrib_stall != '0) begin
			stall_cycles <= stall_cycles + 1;
		end
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the engine never went idle", cycles);
			$display("Entries read: %0d, errors: %0d", reads, errors);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clock);
		#10;
	endtask

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
		$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		errors++;
	endtask

	// Random destinations in 0 .. dest_range-1
	task automatic load_graph(int dest_range);
		for (int a = 0; a < 256; a++) begin
			model_dest[a] = VERTEX_W'($urandom % dest_range);
			edge_wr       = 1'b1;
			edge_wr_addr  = EDGE_W'(a);
			edge_wr_dest  = model_dest[a];
			next_cycle();
		end
		edge_wr = 1'b0;
	endtask

	task automatic push_job(logic [15:0] rank, logic [15:0] inv, logic [7:0] base,
			logic [8:0] deg);
		logic [31:0] prod;
		logic [7:0]  addr;
		prod = 32'(rank) * 32'(inv);
		addr = base;
		// Integer part of the product, fraction dropped
		for (int e = 0; e < deg; e++) begin
			model_rank[model_dest[addr]] += ACC_W'(prod[31:16]);
			addr++;
		end
		exp_vertex++;
		exp_edge += COUNT_W'(deg);
		job_strobe     = 1'b1;
		job_rank       = rank;
		job_inv_degree = inv;
		job_edge_base  = base;
		job_out_degree = deg;
		next_cycle();
		job_strobe = 1'b0;
	endtask

	task automatic wait_idle();
		while (busy) begin
			next_cycle();
		end
	endtask

	task automatic check_counts();
		if (vertex_count !== exp_vertex) report_mismatch("vertex_count", vertex_count, exp_vertex);
		if (edge_count !== exp_edge) report_mismatch("edge_count", edge_count, exp_edge);
	endtask

	// One read per entry, rd_valid must last exactly one cycle
	task automatic check_array();
		for (int v = 0; v < 64; v++) begin
			rd_strobe = 1'b1;
			rd_addr   = VERTEX_W'(v);
			next_cycle();
			rd_strobe = 1'b0;
			reads++;
			if (rd_valid !== 1'b1) report_mismatch("rd_valid", rd_valid, 1);
			if (rd_data !== model_rank[v]) begin
				report_mismatch($sformatf("rd_data[%0d]", v), rd_data, model_rank[v]);
			end
			next_cycle();
			if (rd_valid !== 1'b0) report_mismatch("rd_valid", rd_valid, 0);
		end
	endtask

	task automatic clear_all();
		clear = 1'b1;
		next_cycle();
		clear = 1'b0;
		for (int v = 0; v < 64; v++) begin
			model_rank[v] = '0;
		end
		exp_vertex = '0;
		exp_edge   = '0;
	endtask

	task automatic random_round(int num_jobs, int max_deg);
		for (int j = 0; j < num_jobs; j++) begin
			push_job(16'($urandom), 16'($urandom), 8'($urandom),
				9'($urandom % (max_deg + 1)));
		end
		wait_idle();
		check_counts();
		check_array();
	endtask

	initial begin
		void'($urandom(32'h8fea));
		rstn           = 1'b0;
		job_strobe     = 1'b0;
		job_rank       = '0;
		job_inv_degree = '0;
		job_edge_base  = '0;
		job_out_degree = '0;
		edge_wr        = 1'b0;
		edge_wr_addr   = '0;
		edge_wr_dest   = '0;
		clear          = 1'b0;
		rd_strobe      = 1'b0;
		rd_addr        = '0;
		for (int v = 0; v < 64; v++) begin
			model_rank[v] = '0;
		end
		exp_vertex = '0;
		exp_edge   = '0;
		repeat (8) @(posedge clock);
		#10;
		rstn = 1'b1;
		next_cycle();

		// Idle state after reset
		if (busy !== 1'b0) report_mismatch("busy", busy, 0);
		if (rd_valid !== 1'b0) report_mismatch("rd_valid", rd_valid, 0);
		check_counts();
		check_array();

		// Single job, few destinations so they repeat, edge walk wraps
		load_graph(4);
		push_job(16'($urandom), 16'($urandom), 8'd250, 9'd12);
		wait_idle();
		check_counts();
		check_array();

		// Full job queue, degrees 0 to 20
		clear_all();
		load_graph(64);
		random_round(16, 20);

		// Long walks onto two destinations, queues must stall
		clear_all();
		load_graph(2);
		stall_base = stall_cycles;
		for (int j = 0; j < 4; j++) begin
			push_job(16'($urandom), 16'($urandom), 8'($urandom), 9'(200 + $urandom % 57));
		end
		wait_idle();
		check_counts();
		check_array();
		if (stall_cycles == stall_base) begin
			$display("No contribution queue stalled during the long walks");
			errors++;
		end

		// Clear, then a fresh round
		clear_all();
		check_counts();
		check_array();
		load_graph(64);
		random_round(12, 20);

		$display("Entries read: %0d, errors: %0d", reads, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/pagerank_pkg.sv
logic/sync_fifo.sv
logic/vertex_dispatch.sv
logic/edge_list_mem.sv
logic/cu_vertex_pagerank.sv
logic/rank_accumulator.sv
logic/pagerank_engine.sv
verif/pagerank_assert.sv
verif/pagerank_tb.sv

// ==== Bender.yml ====
package:
  name: pagerank_engine

sources:
  - files:
      - logic/pagerank_pkg.sv
      - logic/sync_fifo.sv
      - logic/vertex_dispatch.sv
      - logic/edge_list_mem.sv
      - logic/cu_vertex_pagerank.sv
      - logic/rank_accumulator.sv
      - logic/pagerank_engine.sv
  - target: test
    files:
      - verif/pagerank_assert.sv
      - verif/pagerank_tb.sv
